//--- Bender.yml
package:
  name: cpu_ctrl

sources:
  - seq_pkg.sv
  - mem_req_if.sv
  - mem_fault_check.sv
  - stage_fsm.sv
  - trap_cause.sv
  - cpu_ctrl_top.sv
  - target: test
    files:
      - tb_cpu_ctrl.sv

//--- compile.f
seq_pkg.sv
mem_req_if.sv
mem_fault_check.sv
stage_fsm.sv
trap_cause.sv
cpu_ctrl_top.sv
tb_cpu_ctrl.sv

//--- cpu_ctrl_top.sv
`timescale 1ns/1ps

module cpu_ctrl_top import seq_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_req,
    input  logic [31:0]           mem_addr,
    input  mem_size_t             mem_size,
    input  logic                  mem_is_store,
    input  logic                  illegal_instr,
    input  logic                  ext_irq,
    input  logic                  sw_irq,
    output logic [num_stages-1:0] stage_active_n,
    output ctrl_op_t              control_op,
    output fault_num_t            fault_num,
    output logic                  trap_valid,
    output logic                  trap_is_int,
    output cause_t                trap_code
);

    logic mem_addr_fault;
    logic mem_access_fault;
    logic mem_fault_is_store;
    logic ext_int;
    logic sw_int;

    mem_req_if mem_bus ();

    // Request from the pins
    assign mem_bus.req      = mem_req;
    assign mem_bus.addr     = mem_addr;
    assign mem_bus.size     = mem_size;
    assign mem_bus.is_store = mem_is_store;

    mem_fault_check mem_fault_check_inst (
        .mem                (mem_bus.check),
        .mem_addr_fault     (mem_addr_fault),
        .mem_access_fault   (mem_access_fault),
        .mem_fault_is_store (mem_fault_is_store)
    );

    stage_fsm stage_fsm_inst (
        .clk                 (clk),
        .rst_n               (rst_n),
        .illegal_instr_fault (illegal_instr),
        .mem_addr_fault      (mem_addr_fault),
        .mem_access_fault    (mem_access_fault),
        .mem_fault_is_store  (mem_fault_is_store),
        .ext_int             (ext_int),
        .sw_int              (sw_int),
        .stage_active_n      (stage_active_n),
        .control_op          (control_op),
        .fault_num           (fault_num)
    );

    // Pending levels loop back into the sequencer
    trap_cause trap_cause_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .ext_irq        (ext_irq),
        .sw_irq         (sw_irq),
        .stage_active_n (stage_active_n),
        .control_op     (control_op),
        .fault_num      (fault_num),
        .ext_int        (ext_int),
        .sw_int         (sw_int),
        .trap_valid     (trap_valid),
        .trap_is_int    (trap_is_int),
        .trap_code      (trap_code)
    );

endmodule

//--- mem_fault_check.sv
`timescale 1ns/1ps

module mem_fault_check import seq_pkg::*; (
    mem_req_if.check mem,
    output logic     mem_addr_fault,
    output logic     mem_access_fault,
    output logic     mem_fault_is_store
);

    logic misaligned;
    logic out_of_range;

    // Alignment rule per access width
    always_comb begin
        case (mem.size)
            size_byte: begin
                misaligned = 1'b0;
            end
            size_half: begin
                misaligned = mem.addr[0];
            end
            size_word: begin
                misaligned = |mem.addr[1:0];
            end
            default: begin
                misaligned = 1'b1; // Reserved width, treated as bad address
            end
        endcase
    end

    assign out_of_range = (mem.addr >= mem_bytes);

    // Misalignment masks the access fault
    assign mem_addr_fault   = mem.req & misaligned;
    assign mem_access_fault = mem.req & ~misaligned & out_of_range;

    // Stage decides whether a store matters
    assign mem_fault_is_store = mem.is_store;

endmodule

//--- mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if import seq_pkg::*; ();

    logic        req;      // Level, held while the stage presents it
    logic [31:0] addr;
    mem_size_t   size;
    logic        is_store;

    // Requesting side
    modport source (
        output req,
        output addr,
        output size,
        output is_store
    );

    // Fault checker side
    modport check (
        input req,
        input addr,
        input size,
        input is_store
    );

endinterface

//--- seq_pkg.sv
package seq_pkg;

    // Ring geometry
    localparam int num_stages = 6;

    // Bit index of each stage in the stage vector
    localparam int stage_control   = 0;
    localparam int stage_fetch     = 1;
    localparam int stage_decode    = 2;
    localparam int stage_execute   = 3;
    localparam int stage_memory    = 4;
    localparam int stage_writeback = 5;

    // Active-high form of the reset stage
    localparam logic [num_stages-1:0] default_stage_active = num_stages'(1) << stage_control;

    // Operation chosen at each entry into control
    typedef enum logic [1:0] {
        op_trap    = 2'b00,
        op_ext_int = 2'b01,
        op_sw_int  = 2'b10,
        op_normal  = 2'b11
    } ctrl_op_t;

    // Fault number layout
    //   bit 2 : memory stage
    //   bit 1 : store, or illegal instruction
    //   bit 0 : access fault instead of misalignment
    typedef logic [2:0] fault_num_t;

    localparam fault_num_t fault_instr_misaligned = 3'b000;
    localparam fault_num_t fault_instr_access     = 3'b001;
    localparam fault_num_t fault_illegal          = 3'b010;
    localparam fault_num_t fault_load_misaligned  = 3'b100;
    localparam fault_num_t fault_load_access      = 3'b101;
    localparam fault_num_t fault_store_misaligned = 3'b110;
    localparam fault_num_t fault_store_access     = 3'b111;

    // Access width of a memory request
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } mem_size_t;

    // Legal address range, anything at or above faults
    localparam int unsigned mem_bytes = 32'd65536;

    // RISC-V style exception code
    typedef logic [3:0] cause_t;

    localparam cause_t cause_ext_int = 4'd11; // Machine external interrupt
    localparam cause_t cause_sw_int  = 4'd3;  // Machine software interrupt

endpackage

//--- stage_fsm.sv
`timescale 1ns/1ps

module stage_fsm import seq_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  illegal_instr_fault, // From the decoder
    input  logic                  mem_addr_fault,
    input  logic                  mem_access_fault,
    input  logic                  mem_fault_is_store,
    input  logic                  ext_int,             // Pending level
    input  logic                  sw_int,              // Pending level
    output logic [num_stages-1:0] stage_active_n,      // One-hot and active low
    output ctrl_op_t              control_op,
    output fault_num_t            fault_num
);

    logic                  in_progress;       // High in the second cycle of a stage
    logic                  mem_fault;
    logic                  fetch_mem_fault;
    logic                  mem_stage_fault;
    logic                  illegal_fault;
    logic                  active_fault;
    logic                  update_control_op;
    fault_num_t            active_fault_num;
    ctrl_op_t              control_op_next;
    logic [num_stages-1:0] rotated_n;
    logic [num_stages-1:0] next_stage_active_n;

    // Two cycles per stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_progress <= 1'b0;
        end else begin
            in_progress <= ~in_progress;
        end
    end

    // Memory faults count only in fetch and memory
    assign mem_fault       = mem_addr_fault | mem_access_fault;
    assign fetch_mem_fault = mem_fault & ~stage_active_n[stage_fetch];
    assign mem_stage_fault = mem_fault & ~stage_active_n[stage_memory];
    assign illegal_fault   = illegal_instr_fault & stage_active_n[stage_control];
    assign active_fault    = in_progress & (fetch_mem_fault | mem_stage_fault | illegal_fault);

    // Illegal instruction wins over a memory fault
    always_comb begin
        if (illegal_fault) begin
            active_fault_num = fault_illegal;
        end else if (mem_stage_fault) begin
            case ({mem_fault_is_store, mem_addr_fault})
                2'b11:   active_fault_num = fault_store_misaligned;
                2'b10:   active_fault_num = fault_store_access;
                2'b01:   active_fault_num = fault_load_misaligned;
                default: active_fault_num = fault_load_access;
            endcase
        end else if (mem_addr_fault) begin
            active_fault_num = fault_instr_misaligned;
        end else begin
            active_fault_num = fault_instr_access;
        end
    end

    // Trap beats both pending interrupts
    always_comb begin
        if (active_fault) begin
            control_op_next = op_trap;
        end else if (ext_int) begin
            control_op_next = op_ext_int;
        end else if (sw_int) begin
            control_op_next = op_sw_int;
        end else begin
            control_op_next = op_normal;
        end
    end

    assign rotated_n = {stage_active_n[num_stages-2:0], stage_active_n[num_stages-1]};

    // Reload on entry into control by rotation or by fault
    assign update_control_op = in_progress & (~rotated_n[stage_control] | active_fault);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            control_op <= op_trap;
            fault_num  <= '0;
        end else begin
            if (update_control_op) begin
                control_op <= control_op_next;
            end
            if (active_fault) begin
                fault_num <= active_fault_num;
            end
        end
    end

    always_comb begin
        if (!in_progress) begin
            next_stage_active_n = stage_active_n;         // Hold in the first cycle
        end else if (active_fault) begin
            next_stage_active_n = ~default_stage_active;  // Back to control
        end else begin
            next_stage_active_n = rotated_n;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_active_n <= ~default_stage_active;
        end else begin
            stage_active_n <= next_stage_active_n;
        end
    end

endmodule

//--- tb_cpu_ctrl.sv
`timescale 1ns/1ps

module tb_cpu_ctrl import seq_pkg::*; ();

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  mem_req;
    logic [31:0]           mem_addr;
    mem_size_t             mem_size;
    logic                  mem_is_store;
    logic                  illegal_instr;
    logic                  ext_irq;
    logic                  sw_irq;
    logic [num_stages-1:0] stage_active_n;
    ctrl_op_t              control_op;
    fault_num_t            fault_num;
    logic                  trap_valid;
    logic                  trap_is_int;
    cause_t                trap_code;

    int          errors = 0;
    int          errors_before = 0;
    int          tests_run = 0;
    logic        check_en = 1'b0;
    logic [31:0] lfsr_state = 32'h667;

    // Reference model state
    int          ref_stage;
    logic        ref_second;   // Second cycle of the current stage
    logic        ref_entry;    // First cycle of a control stage
    ctrl_op_t    ref_op;
    fault_num_t  ref_fnum;
    logic        ref_ext_pend;
    logic        ref_sw_pend;

    logic [num_stages-1:0] exp_stage_n;
    logic                  exp_trap_valid;
    logic                  exp_is_int;
    cause_t                exp_code;

    cpu_ctrl_top cpu_ctrl_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_size       (mem_size),
        .mem_is_store   (mem_is_store),
        .illegal_instr  (illegal_instr),
        .ext_irq        (ext_irq),
        .sw_irq         (sw_irq),
        .stage_active_n (stage_active_n),
        .control_op     (control_op),
        .fault_num      (fault_num),
        .trap_valid     (trap_valid),
        .trap_is_int    (trap_is_int),
        .trap_code      (trap_code)
    );

    always #10 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
        end
        return value;
    endfunction

    // Bit 1 misaligned, bit 0 out of range
    function automatic logic [1:0] mem_fault_kind(logic req, logic [31:0] addr, mem_size_t size);
        logic mis;
        mis = (size == size_half && addr[0]) || (size == size_word && addr[1:0] != 2'b00);
        if (!req) return 2'b00;
        if (mis) return 2'b10;
        return (addr >= mem_bytes) ? 2'b01 : 2'b00;
    endfunction

    always @(posedge clk) begin
        logic [1:0] kind;
        logic       illegal_hit;
        logic       stage_fault;
        logic       entering;
        fault_num_t num;
        kind = mem_fault_kind(mem_req, mem_addr, mem_size);
        illegal_hit = illegal_instr && ref_stage != stage_control;
        stage_fault = ref_second && (illegal_hit || (kind != 2'b00 &&
                      (ref_stage == stage_fetch || ref_stage == stage_memory)));
        if (illegal_hit) begin
            num = fault_illegal;
        end else begin
            num = {ref_stage == stage_memory, ref_stage == stage_memory && mem_is_store, kind[0]};
        end
        entering = ref_second && (stage_fault || ref_stage == stage_writeback);
        if (!rst_n) begin
            ref_stage    <= stage_control;
            ref_second   <= 1'b0;
            ref_entry    <= 1'b0;
            ref_op       <= op_trap;
            ref_fnum     <= '0;
            ref_ext_pend <= 1'b0;
            ref_sw_pend  <= 1'b0;
        end else begin
            ref_second   <= ~ref_second;
            ref_entry    <= entering;
            ref_ext_pend <= ext_irq || (ref_ext_pend && !(exp_trap_valid && ref_op == op_ext_int));
            ref_sw_pend  <= sw_irq || (ref_sw_pend && !(exp_trap_valid && ref_op == op_sw_int));
            if (stage_fault) begin
                ref_stage <= stage_control;
                ref_fnum  <= num;
            end else if (ref_second) begin
                ref_stage <= (ref_stage + 1) % num_stages;
            end
            if (entering) begin
                ref_op <= stage_fault ? op_trap : ref_ext_pend ? op_ext_int :
                          ref_sw_pend ? op_sw_int : op_normal;
            end
        end
    end

    assign exp_stage_n    = ~(num_stages'(1) << ref_stage);
    assign exp_trap_valid = ref_entry && ref_op != op_normal;
    assign exp_is_int     = exp_trap_valid && (ref_op == op_ext_int || ref_op == op_sw_int);
    assign exp_code       = (ref_op == op_ext_int) ? cause_ext_int :
                            (ref_op == op_sw_int) ? cause_sw_int : {1'b0, ref_fnum};

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("FAILED t=%0t %s got %0h expected %0h", $time, name, got, want);
        errors++;
    endtask

    // Sampled at the falling edge, away from the drive point
    assert property (@(negedge clk) disable iff (!check_en) stage_active_n == exp_stage_n)
        else report_mismatch("stage_active_n", stage_active_n, exp_stage_n);
    assert property (@(negedge clk) disable iff (!check_en) control_op == ref_op)
        else report_mismatch("control_op", control_op, ref_op);
    assert property (@(negedge clk) disable iff (!check_en) fault_num == ref_fnum)
        else report_mismatch("fault_num", fault_num, ref_fnum);
    assert property (@(negedge clk) disable iff (!check_en) trap_valid == exp_trap_valid)
        else report_mismatch("trap_valid", trap_valid, exp_trap_valid);
    assert property (@(negedge clk) disable iff (!check_en) trap_is_int == exp_is_int)
        else report_mismatch("trap_is_int", trap_is_int, exp_is_int);
    assert property (@(negedge clk) disable iff (!check_en)
                     (!exp_trap_valid || trap_code == exp_code))
        else report_mismatch("trap_code", trap_code, exp_code);

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got == want) else report_mismatch(name, got, want);
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic abort_run(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    // Returns in the first cycle of the stage
    task automatic wait_stage_entry(input int idx);
        logic was_active;
        int   cycles;
        cycles = 0;
        was_active = ~stage_active_n[idx];
        step();
        while (stage_active_n[idx] || was_active) begin
            if (cycles == 40) abort_run("a stage entry");
            was_active = ~stage_active_n[idx];
            step();
            cycles++;
        end
    endtask

    task automatic wait_trap();
        int cycles;
        cycles = 0;
        while (!trap_valid) begin
            if (cycles == 40) abort_run("trap_valid");
            step();
            cycles++;
        end
    endtask

    // Holds the inputs over both cycles of the current stage
    task automatic present_request(input logic req, input logic [31:0] addr,
                                   input mem_size_t size, input logic store, input logic illegal);
        mem_req       = req;
        mem_addr      = addr;
        mem_size      = size;
        mem_is_store  = store;
        illegal_instr = illegal;
        step();
        step();
        mem_req       = 1'b0;
        illegal_instr = 1'b0;
    endtask

    task automatic pulse_irq(input logic ext, input logic sw);
        ext_irq = ext;
        sw_irq  = sw;
        step();
        ext_irq = 1'b0;
        sw_irq  = 1'b0;
    endtask

    task automatic expect_trap(input ctrl_op_t op, input cause_t code, input logic is_int);
        wait_trap();
        check_value("control_op", control_op, op);
        check_value("trap_code", trap_code, code);
        check_value("trap_is_int", trap_is_int, is_int);
        step();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %0d %s done with %0d errors", tests_run, name, errors - errors_before);
        errors_before = errors;
    endtask

    task automatic test_rotation();
        logic [num_stages-1:0] want;
        int                    k;
        wait_stage_entry(stage_control);
        for (k = 0; k < 12; k++) begin
            want = ~(num_stages'(1) << (k / 2));
            check_value("stage_active_n", stage_active_n, want);
            check_value("trap_valid", trap_valid, 1'b0);
            step();
        end
        check_value("control_op", control_op, op_normal);
        end_test("normal rotation");
    endtask

    task automatic test_mem_faults();
        logic [31:0] addr;
        mem_size_t   size;
        logic        store;
        logic        access;
        int          n;
        for (n = 0; n < 8; n++) begin
            store  = lfsr_bits(1);
            size   = lfsr_bits(1) ? size_word : size_half;
            access = lfsr_bits(1);
            if (access) begin
                addr = (lfsr_bits(32) | 32'h0001_0000) & 32'hffff_fffc; // Aligned, out of range
            end else begin
                addr = lfsr_bits(16);
                addr[1:0] = (size == size_word && lfsr_bits(1)) ? 2'b10 : 2'b01;
            end
            wait_stage_entry(stage_memory);
            present_request(1'b1, addr, size, store, 1'b0);
            check_value("fault_num", fault_num, {1'b1, store, access});
            expect_trap(op_trap, {2'b01, store, access}, 1'b0);
        end
        end_test("memory stage faults");
    endtask

    task automatic test_fetch_illegal();
        wait_stage_entry(stage_fetch);
        present_request(1'b1, 32'h0000_0102, size_word, 1'b0, 1'b0);
        expect_trap(op_trap, 4'd0, 1'b0);
        wait_stage_entry(stage_fetch);
        present_request(1'b1, 32'h0002_0000, size_word, 1'b0, 1'b0);
        expect_trap(op_trap, 4'd1, 1'b0);
        wait_stage_entry(stage_decode);
        present_request(1'b0, 32'h0, size_byte, 1'b0, 1'b1);
        wait_trap();
        check_value("trap_code", trap_code, 4'd2);
        present_request(1'b1, 32'h0000_0003, size_word, 1'b0, 1'b1); // In control
        check_value("stage_active_n", stage_active_n, 6'b111101);
        wait_stage_entry(stage_decode);
        present_request(1'b1, 32'h0000_0001, size_half, 1'b1, 1'b0);
        check_value("stage_active_n", stage_active_n, 6'b110111);
        end_test("fetch faults and illegal instructions");
    endtask

    task automatic test_interrupts();
        wait_stage_entry(stage_execute);
        pulse_irq(1'b1, 1'b0);
        expect_trap(op_ext_int, cause_ext_int, 1'b1);
        pulse_irq(1'b0, 1'b1);
        expect_trap(op_sw_int, cause_sw_int, 1'b1);
        pulse_irq(1'b1, 1'b1);
        expect_trap(op_ext_int, cause_ext_int, 1'b1);
        expect_trap(op_sw_int, cause_sw_int, 1'b1);
        wait_stage_entry(stage_fetch);
        pulse_irq(1'b1, 1'b0);
        wait_stage_entry(stage_decode);
        present_request(1'b0, 32'h0, size_byte, 1'b0, 1'b1);
        expect_trap(op_trap, 4'd2, 1'b0);
        expect_trap(op_ext_int, cause_ext_int, 1'b1);
        end_test("interrupts");
    endtask

    initial begin
        rst_n         = 1'b0;
        mem_req       = 1'b0;
        mem_addr      = '0;
        mem_size      = size_byte;
        mem_is_store  = 1'b0;
        illegal_instr = 1'b0;
        ext_irq       = 1'b0;
        sw_irq        = 1'b0;
        step();
        check_en = 1'b1; // Model has seen a reset edge
        repeat (3) step();
        rst_n = 1'b1;
        check_value("stage_active_n", stage_active_n, 6'b111110);
        check_value("control_op", control_op, 2'b00);
        check_value("fault_num", fault_num, 3'b000);
        check_value("trap_valid", trap_valid, 1'b0);
        end_test("reset state");
        test_rotation();
        test_mem_faults();
        test_fetch_illegal();
        test_interrupts();
        wait_stage_entry(stage_memory);
        present_request(1'b1, 32'h0000_1234, size_word, 1'b1, 1'b0);
        check_value("stage_active_n", stage_active_n, 6'b011111);
        check_value("trap_valid", trap_valid, 1'b0);
        end_test("clean memory request");
        repeat (2) step();
        $display("%0d tests run, %0d checks failed", tests_run, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- trap_cause.sv
`timescale 1ns/1ps

module trap_cause import seq_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ext_irq,
    input  logic                  sw_irq,
    input  logic [num_stages-1:0] stage_active_n,
    input  ctrl_op_t              control_op,
    input  fault_num_t            fault_num,
    output logic                  ext_int,     // Pending external interrupt
    output logic                  sw_int,      // Pending software interrupt
    output logic                  trap_valid,
    output logic                  trap_is_int,
    output cause_t                trap_code
);

    logic [num_stages-1:0] stage_prev_n;
    logic                  control_entry;
    logic                  take_ext;
    logic                  take_sw;

    // Previous stage vector for edge detection
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_prev_n <= ~default_stage_active; // Masks the control stage after reset
        end else begin
            stage_prev_n <= stage_active_n;
        end
    end

    // First cycle of control
    assign control_entry = ~stage_active_n[stage_control] & (stage_active_n != stage_prev_n);

    assign trap_valid  = control_entry & (control_op != op_normal);
    assign trap_is_int = trap_valid & (control_op inside {op_ext_int, op_sw_int});

    assign take_ext = trap_valid & (control_op == op_ext_int);
    assign take_sw  = trap_valid & (control_op == op_sw_int);

    // A new request beats the clear of the one just taken
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ext_int <= 1'b0;
            sw_int  <= 1'b0;
        end else begin
            ext_int <= ext_irq | (ext_int & ~take_ext);
            sw_int  <= sw_irq | (sw_int & ~take_sw);
        end
    end

    always_comb begin
        case (control_op)
            op_trap: begin
                trap_code = cause_t'(fault_num); // Fault number doubles as exception code
            end
            op_ext_int: begin
                trap_code = cause_ext_int;
            end
            op_sw_int: begin
                trap_code = cause_sw_int;
            end
            default: begin
                trap_code = '0;
            end
        endcase
    end

endmodule
